//--- hdl/simd_pkg.sv
`default_nettype none

package simd_pkg;

  localparam int LANE_W  = 32;
  localparam int N_LANES = 2;
  localparam int WORD_W  = LANE_W * N_LANES;
  localparam int N_BUSES = 4;

  typedef logic [LANE_W-1:0] lane_t;

  // Lane 0 sits in the low half of the word
  typedef logic [WORD_W-1:0] word_t;

  // Codes 0 to 3 name a result bus
  typedef logic [2:0] fwd_src_t;

  localparam fwd_src_t FWD_REG = 3'd4;

  // Two bits per lane with less-than in the even bit and equal in the odd bit
  typedef logic [2*N_LANES-1:0] flags_t;

  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_SUB   = 3'd1,
    ALU_AND   = 3'd2,
    ALU_OR    = 3'd3,
    ALU_XOR   = 3'd4,
    ALU_CMPLT = 3'd5
  } alu_op_t;

  typedef enum logic [1:0] {
    PERM_PASS   = 2'd0,
    PERM_SWAP   = 2'd1,
    PERM_DUP_LO = 2'd2,
    PERM_MERGE  = 2'd3
  } perm_op_t;

endpackage

`default_nettype wire

//--- hdl/operand_fwd.sv
`timescale 1ns/100ps
`default_nettype none

module operand_fwd
  import simd_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            in_valid,
  input  wire [2:0]      in_op,
  input  wire word_t     reg_a,
  input  wire word_t     reg_b,
  input  wire fwd_src_t  src_a,
  input  wire fwd_src_t  src_b,
  input  wire            late_a,
  input  wire            late_b,
  input  wire word_t     bus0,
  input  wire word_t     bus1,
  input  wire word_t     bus2,
  input  wire word_t     bus3,
  output logic           out_valid,
  output logic [2:0]     out_op,
  output word_t          opnd_a,
  output word_t          opnd_b
);

  word_t bus_now [N_BUSES];
  word_t bus_q   [N_BUSES];
  word_t sel_a;
  word_t sel_b;

  function automatic word_t pick_operand(
    input fwd_src_t src,
    input logic     late,
    input word_t    reg_val,
    input word_t    live [N_BUSES],
    input word_t    held [N_BUSES]
  );
    if (src == FWD_REG) return reg_val;
    return late ? held[src[1:0]] : live[src[1:0]];
  endfunction

  assign bus_now[0] = bus0;
  assign bus_now[1] = bus1;
  assign bus_now[2] = bus2;
  assign bus_now[3] = bus3;

  // One edge of bus history for late forwards
  always_ff @(posedge clk) begin
    for (int i = 0; i < N_BUSES; i++) begin
      bus_q[i] <= rst ? '0 : bus_now[i];
    end
  end

  assign sel_a = pick_operand(src_a, late_a, reg_a, bus_now, bus_q);
  assign sel_b = pick_operand(src_b, late_b, reg_b, bus_now, bus_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_op <= in_op;
      opnd_a <= sel_a;
      opnd_b <= sel_b;
    end
  end

endmodule

`default_nettype wire

//--- hdl/simd_alu.sv
`timescale 1ns/100ps
`default_nettype none

module simd_alu
  import simd_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  wire           in_valid,
  input  wire alu_op_t  op,
  input  wire word_t    opnd_a,
  input  wire word_t    opnd_b,
  output word_t         res,
  output flags_t        flags,
  output logic          res_valid
);

  word_t  res_d;
  flags_t flags_d;

  // Each lane is computed on its own, so add and subtract never carry across lanes
  always_comb begin : lane_ops
    lane_t a;
    lane_t b;
    lane_t r;
    logic  lt;
    logic  eq;
    res_d   = '0;
    flags_d = '0;
    for (int i = 0; i < N_LANES; i++) begin
      a  = opnd_a[i*LANE_W +: LANE_W];
      b  = opnd_b[i*LANE_W +: LANE_W];
      lt = $signed(a) < $signed(b);
      eq = (a == b);
      case (op)
        ALU_ADD: begin
          r = a + b;
        end
        ALU_SUB: begin
          r = a - b;
        end
        ALU_AND: begin
          r = a & b;
        end
        ALU_OR: begin
          r = a | b;
        end
        ALU_XOR: begin
          r = a ^ b;
        end
        ALU_CMPLT: begin
          r              = {LANE_W{lt}};
          flags_d[2*i]   = lt;
          flags_d[2*i+1] = eq;
        end
        default: begin
          r = '0;
        end
      endcase
      res_d[i*LANE_W +: LANE_W] = r;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= in_valid;
    end
  end

  // Flags stay zero unless the op was a compare
  always_ff @(posedge clk) begin
    if (in_valid) begin
      res   <= res_d;
      flags <= flags_d;
    end
  end

endmodule

`default_nettype wire

//--- hdl/simd_perm.sv
`timescale 1ns/100ps
`default_nettype none

module simd_perm
  import simd_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            in_valid,
  input  wire perm_op_t  op,
  input  wire word_t     opnd_a,
  input  wire word_t     opnd_b,
  output word_t          res,
  output logic           res_valid
);

  lane_t a_lo;
  lane_t a_hi;
  lane_t b_lo;
  word_t res_d;

  assign a_lo = opnd_a[LANE_W-1:0];
  assign a_hi = opnd_a[WORD_W-1:LANE_W];
  assign b_lo = opnd_b[LANE_W-1:0];

  always_comb begin
    case (op)
      PERM_PASS:   res_d = {a_hi, a_lo};
      PERM_SWAP:   res_d = {a_lo, a_hi};
      PERM_DUP_LO: res_d = {a_lo, a_lo};
      PERM_MERGE:  res_d = {a_hi, b_lo};
      default:     res_d = opnd_a;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) res <= res_d;
  end

endmodule

`default_nettype wire

//--- hdl/simd_unit.sv
`timescale 1ns/100ps
`default_nettype none

module simd_unit
  import simd_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            p1_valid,
  input  wire alu_op_t   p1_op,
  input  wire word_t     p1_reg_a,
  input  wire word_t     p1_reg_b,
  input  wire fwd_src_t  p1_src_a,
  input  wire fwd_src_t  p1_src_b,
  input  wire            p1_late_a,
  input  wire            p1_late_b,
  input  wire            p2_valid,
  input  wire perm_op_t  p2_op,
  input  wire word_t     p2_reg_a,
  input  wire word_t     p2_reg_b,
  input  wire fwd_src_t  p2_src_a,
  input  wire fwd_src_t  p2_src_b,
  input  wire            p2_late_a,
  input  wire            p2_late_b,
  input  wire word_t     bus0,
  input  wire word_t     bus1,
  input  wire word_t     bus2,
  input  wire word_t     bus3,
  output word_t          res1,
  output flags_t         flags1,
  output logic           res1_valid,
  output word_t          res2,
  output logic           res2_valid
);

  logic       fwd1_valid;
  logic [2:0] fwd1_op;
  word_t      fwd1_a;
  word_t      fwd1_b;
  logic       fwd2_valid;
  logic [2:0] fwd2_op;
  word_t      fwd2_a;
  word_t      fwd2_b;

  // Port 1 carries ALU ops
  operand_fwd fwd1 (
    .clk(clk), .rst(rst),
    .in_valid(p1_valid), .in_op(p1_op),
    .reg_a(p1_reg_a), .reg_b(p1_reg_b),
    .src_a(p1_src_a), .src_b(p1_src_b),
    .late_a(p1_late_a), .late_b(p1_late_b),
    .bus0(bus0), .bus1(bus1), .bus2(bus2), .bus3(bus3),
    .out_valid(fwd1_valid), .out_op(fwd1_op),
    .opnd_a(fwd1_a), .opnd_b(fwd1_b)
  );

  // Port 2 ops are two bits wide, so the top op bit is tied low
  operand_fwd fwd2 (
    .clk(clk), .rst(rst),
    .in_valid(p2_valid), .in_op({1'b0, p2_op}),
    .reg_a(p2_reg_a), .reg_b(p2_reg_b),
    .src_a(p2_src_a), .src_b(p2_src_b),
    .late_a(p2_late_a), .late_b(p2_late_b),
    .bus0(bus0), .bus1(bus1), .bus2(bus2), .bus3(bus3),
    .out_valid(fwd2_valid), .out_op(fwd2_op),
    .opnd_a(fwd2_a), .opnd_b(fwd2_b)
  );

  simd_alu alu (
    .clk(clk), .rst(rst),
    .in_valid(fwd1_valid), .op(alu_op_t'(fwd1_op)),
    .opnd_a(fwd1_a), .opnd_b(fwd1_b),
    .res(res1), .flags(flags1), .res_valid(res1_valid)
  );

  simd_perm perm (
    .clk(clk), .rst(rst),
    .in_valid(fwd2_valid), .op(perm_op_t'(fwd2_op[1:0])),
    .opnd_a(fwd2_a), .opnd_b(fwd2_b),
    .res(res2), .res_valid(res2_valid)
  );

endmodule

`default_nettype wire

//--- verif/simd_unit_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module simd_unit_asserts
  import simd_pkg::*;
(
  input wire          clk,
  input wire          rst,
  input wire          p1_valid,
  input wire          p2_valid,
  input wire alu_op_t p1_op,
  input wire flags_t  flags1,
  input wire          res1_valid,
  input wire          res2_valid
);

  int fail_count = 0;

  a_reset_valids: assert property (@(posedge clk) rst |=> !res1_valid && !res2_valid)
    else begin
      fail_count++;
      $error("result valid high while reset is asserted");
    end

  // Both ports have a fixed two cycle latency
  a_p1_latency: assert property (@(posedge clk) disable iff (rst)
    res1_valid == $past(p1_valid, 2))
    else begin
      fail_count++;
      $error("res1_valid does not follow p1_valid by two cycles");
    end

  a_p2_latency: assert property (@(posedge clk) disable iff (rst)
    res2_valid == $past(p2_valid, 2))
    else begin
      fail_count++;
      $error("res2_valid does not follow p2_valid by two cycles");
    end

  a_flags_cmp_only: assert property (@(posedge clk) disable iff (rst)
    (res1_valid && $past(p1_op, 2) != ALU_CMPLT) |-> flags1 == '0)
    else begin
      fail_count++;
      $error("flags1 nonzero for a non-compare op");
    end

endmodule

bind simd_unit simd_unit_asserts asrt (.*);

`default_nettype wire

//--- verif/simd_unit_checker.sv
`timescale 1ns/100ps
`default_nettype none

module simd_unit_checker
  import simd_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  wire           p1_valid,
  input  wire alu_op_t  p1_op,
  input  wire word_t    p1_reg_a, p1_reg_b,
  input  wire fwd_src_t p1_src_a, p1_src_b,
  input  wire           p1_late_a, p1_late_b,
  input  wire           p2_valid,
  input  wire perm_op_t p2_op,
  input  wire word_t    p2_reg_a, p2_reg_b,
  input  wire fwd_src_t p2_src_a, p2_src_b,
  input  wire           p2_late_a, p2_late_b,
  input  wire word_t    bus0, bus1, bus2, bus3,
  input  wire word_t    res1, res2,
  input  wire flags_t   flags1,
  input  wire           res1_valid, res2_valid,
  output int            mismatch_count, unexpected_count, pend1, pend2
);

  word_t  live_bus [N_BUSES];
  word_t  prev_bus [N_BUSES];
  word_t  exp_res1 [$];
  flags_t exp_flags1 [$];
  word_t  exp_res2 [$];
  int     mismatches = 0;
  int     unexpected = 0;

  function automatic lane_t lane_alu(input alu_op_t op, input lane_t x, input lane_t y);
    case (op)
      ALU_ADD:   return x + y;
      ALU_SUB:   return x - y;
      ALU_AND:   return x & y;
      ALU_OR:    return x | y;
      ALU_XOR:   return x ^ y;
      ALU_CMPLT: return ($signed(x) < $signed(y)) ? '1 : '0;
      default:   return '0;
    endcase
  endfunction

  function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
    return {lane_alu(op, a[63:32], b[63:32]), lane_alu(op, a[31:0], b[31:0])};
  endfunction

  // High lane equal, high lane less, low lane equal, low lane less
  function automatic flags_t flags_ref(input alu_op_t op, input word_t a, input word_t b);
    if (op != ALU_CMPLT) return '0;
    return {a[63:32] == b[63:32], $signed(a[63:32]) < $signed(b[63:32]),
            a[31:0] == b[31:0], $signed(a[31:0]) < $signed(b[31:0])};
  endfunction

  function automatic word_t perm_ref(input perm_op_t op, input word_t a, input word_t b);
    case (op)
      PERM_PASS:   return a;
      PERM_SWAP:   return {a[31:0], a[63:32]};
      PERM_DUP_LO: return {a[31:0], a[31:0]};
      default:     return {a[63:32], b[31:0]};
    endcase
  endfunction

  function automatic word_t resolve(input fwd_src_t src, input logic late, input word_t regv);
    if (src == FWD_REG) return regv;
    if (late) return prev_bus[src[1:0]];
    return live_bus[src[1:0]];
  endfunction

  task automatic check_word(input string name, input word_t expv, input word_t got);
    if (got !== expv) begin
      $display("mismatch at %0t: %s expected %h, got %h", $time, name, expv, got);
      mismatches++;
    end
  endtask

  always @(posedge clk) begin : watch
    word_t a;
    word_t b;
    live_bus[0] = bus0;
    live_bus[1] = bus1;
    live_bus[2] = bus2;
    live_bus[3] = bus3;
    if (rst) begin
      exp_res1.delete();
      exp_flags1.delete();
      exp_res2.delete();
      for (int i = 0; i < N_BUSES; i++) prev_bus[i] = '0;
    end else begin
      if (res1_valid && exp_res1.size() == 0) begin
        $display("Port 1 gave a result at %0t with no issue outstanding", $time);
        unexpected++;
      end else if (res1_valid) begin
        check_word("res1", exp_res1.pop_front(), res1);
        check_word("flags1", word_t'(exp_flags1.pop_front()), word_t'(flags1));
      end
      if (res2_valid && exp_res2.size() == 0) begin
        $display("Port 2 gave a result at %0t with no issue outstanding", $time);
        unexpected++;
      end else if (res2_valid) begin
        check_word("res2", exp_res2.pop_front(), res2);
      end
      if (p1_valid) begin
        a = resolve(p1_src_a, p1_late_a, p1_reg_a);
        b = resolve(p1_src_b, p1_late_b, p1_reg_b);
        exp_res1.push_back(alu_ref(p1_op, a, b));
        exp_flags1.push_back(flags_ref(p1_op, a, b));
      end
      if (p2_valid) begin
        a = resolve(p2_src_a, p2_late_a, p2_reg_a);
        b = resolve(p2_src_b, p2_late_b, p2_reg_b);
        exp_res2.push_back(perm_ref(p2_op, a, b));
      end
      for (int i = 0; i < N_BUSES; i++) prev_bus[i] = live_bus[i];
    end
    mismatch_count   <= mismatches;
    unexpected_count <= unexpected;
    pend1            <= exp_res1.size();
    pend2            <= exp_res2.size();
  end

endmodule

`default_nettype wire

//--- verif/simd_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module simd_unit_tb
  import simd_pkg::*;
();

  logic     clk;
  logic     rst;
  logic     p1_valid, p2_valid;
  alu_op_t  p1_op;
  perm_op_t p2_op;
  word_t    p1_reg_a, p1_reg_b, p2_reg_a, p2_reg_b;
  fwd_src_t p1_src_a, p1_src_b, p2_src_a, p2_src_b;
  logic     p1_late_a, p1_late_b, p2_late_a, p2_late_b;
  word_t    bus0, bus1, bus2, bus3;
  word_t    res1, res2;
  flags_t   flags1;
  logic     res1_valid, res2_valid;
  int       mismatch_count, unexpected_count, pend1, pend2;

  simd_unit uut (.*);

  simd_unit_checker chk (.*);

  always #50 clk = ~clk;

  // Edge values show up often so that wraparound and equal lanes get hit
  function automatic lane_t rand_lane();
    case ($urandom_range(0, 7))
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff;
      2:       return 32'h7fff_ffff;
      3:       return 32'h8000_0000;
      default: return $urandom;
    endcase
  endfunction

  function automatic word_t rand_word();
    return {rand_lane(), rand_lane()};
  endfunction

  function automatic fwd_src_t rand_src(input bit reg_only);
    if (reg_only) return FWD_REG;
    return fwd_src_t'($urandom_range(0, 4));
  endfunction

  task automatic drive_buses();
    bus0 <= {$urandom, $urandom};
    bus1 <= {$urandom, $urandom};
    bus2 <= {$urandom, $urandom};
    bus3 <= {$urandom, $urandom};
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    p1_valid <= 1'b0;
    p2_valid <= 1'b0;
    drive_buses();
  endtask

  task automatic issue_alu_regs(input alu_op_t op, input word_t a, input word_t b);
    @(posedge clk);
    p1_valid <= 1'b1;
    p1_op    <= op;
    p1_reg_a <= a;
    p1_reg_b <= b;
    p1_src_a <= FWD_REG;
    p1_src_b <= FWD_REG;
    p2_valid <= 1'b0;
    drive_buses();
  endtask

  task automatic random_cycle(input int valid_pct, input bit reg_only);
    @(posedge clk);
    p1_valid  <= $urandom_range(0, 99) < valid_pct;
    p1_op     <= alu_op_t'(3'($urandom_range(0, 5)));
    p1_reg_a  <= rand_word();
    p1_reg_b  <= rand_word();
    p1_src_a  <= rand_src(reg_only);
    p1_src_b  <= rand_src(reg_only);
    p1_late_a <= 1'($urandom_range(0, 1));
    p1_late_b <= 1'($urandom_range(0, 1));
    p2_valid  <= $urandom_range(0, 99) < valid_pct;
    p2_op     <= perm_op_t'(2'($urandom_range(0, 3)));
    p2_reg_a  <= rand_word();
    p2_reg_b  <= rand_word();
    p2_src_a  <= rand_src(reg_only);
    p2_src_b  <= rand_src(reg_only);
    p2_late_a <= 1'($urandom_range(0, 1));
    p2_late_b <= 1'($urandom_range(0, 1));
    drive_buses();
  endtask

  initial begin
    int wait_cycles;
    int timeouts;
    int missing;
    void'($urandom(32'h380a_a7d9));
    clk = 1'b0;
    rst = 1'b1;
    {p1_valid, p2_valid} = 2'b00;
    p1_op = ALU_ADD;
    p2_op = PERM_PASS;
    {p1_reg_a, p1_reg_b, p2_reg_a, p2_reg_b} = '0;
    {p1_src_a, p1_src_b, p2_src_a, p2_src_b} = {4{FWD_REG}};
    {p1_late_a, p1_late_b, p2_late_a, p2_late_b} = 4'b0000;
    {bus0, bus1, bus2, bus3} = '0;
    timeouts = 0;
    repeat (10) idle_cycle();
    rst <= 1'b0;
    repeat (3) idle_cycle();
    // Carries and borrows must stay inside their lane
    issue_alu_regs(ALU_ADD, 64'h0000_0001_ffff_ffff, 64'h0000_0000_0000_0001);
    issue_alu_regs(ALU_ADD, 64'h7fff_ffff_8000_0000, 64'h0000_0001_8000_0000);
    issue_alu_regs(ALU_SUB, 64'h0000_0000_0000_0000, 64'h0000_0001_0000_0001);
    issue_alu_regs(ALU_AND, 64'hf0f0_f0f0_ffff_0000, 64'hff00_ff00_0f0f_0f0f);
    issue_alu_regs(ALU_OR, 64'hf0f0_0000_1234_0000, 64'h0f0f_0000_0000_5678);
    issue_alu_regs(ALU_XOR, 64'haaaa_aaaa_ffff_ffff, 64'h5555_5555_0f0f_0f0f);
    issue_alu_regs(ALU_CMPLT, 64'hffff_ffff_1234_5678, 64'h0000_0001_1234_5678);
    issue_alu_regs(ALU_CMPLT, 64'h7fff_ffff_8000_0000, 64'h8000_0000_7fff_ffff);
    idle_cycle();
    repeat (200) random_cycle(100, 1'b1);
    repeat (400) random_cycle(85, 1'b0);
    repeat (300) random_cycle(100, 1'b0);
    wait_cycles = 0;
    while ((pend1 != 0 || pend2 != 0) && wait_cycles < 20) begin
      idle_cycle();
      wait_cycles++;
    end
    if (pend1 != 0 || pend2 != 0) begin
      $display("Timed out waiting for the result queues to drain");
      timeouts++;
    end
    repeat (4) idle_cycle();
    missing = pend1 + pend2;
    $display("Errors: %0d mismatches, %0d unexpected, %0d missing, %0d assertion, %0d timeouts",
             mismatch_count, unexpected_count, missing, uut.asrt.fail_count, timeouts);
    if (mismatch_count == 0 && unexpected_count == 0 && missing == 0 &&
        uut.asrt.fail_count == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hdl/simd_pkg.sv
hdl/operand_fwd.sv
hdl/simd_alu.sv
hdl/simd_perm.sv
hdl/simd_unit.sv
verif/simd_unit_asserts.sv
verif/simd_unit_checker.sv
verif/simd_unit_tb.sv

//--- Makefile
VERILATOR := verilator
TOP       := simd_unit_tb
FILELIST  := sources.f
FLAGS     := --timing --assert
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run status of the binary is ignored; the log decides pass or fail
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
